// File: logic/frame_sequencer.sv
module frame_sequencer #(
    parameter int DATA_WIDTH    = 32,
    parameter int PIXEL_WIDTH   = 8,
    parameter int ADDR_WIDTH    = 10,
    parameter int DIM_WIDTH     = 16,
    parameter int IMG_WIDTH_MAX = 64,
    localparam int PIX_PER_WORD = DATA_WIDTH / PIXEL_WIDTH,
    localparam int LANE_CNT_W   = $clog2(PIX_PER_WORD + 1)
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  sobel_pkg::sobel_mode_e  mode,
    input  logic [DIM_WIDTH-1:0]    image_width,
    input  logic [DIM_WIDTH-1:0]    image_height,
    input  logic                    unpack_idle,
    input  logic                    frame_done,
    output logic                    busy,
    output logic                    done,
    output logic                    bram_in_ena,
    output logic [ADDR_WIDTH-1:0]   bram_in_addr,
    output logic                    word_req,
    output logic [LANE_CNT_W-1:0]   lane_count,
    output logic [DIM_WIDTH-1:0]    cfg_width,
    output logic [DIM_WIDTH-1:0]    cfg_height,
    output sobel_pkg::sobel_mode_e  cfg_mode,
    output logic                    frame_start
);

    sobel_pkg::seq_state_e state, state_next;
    logic [2*DIM_WIDTH-1:0] pix_left;  // Pixels not yet requested

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_comb begin
        state_next = state;
        unique case (state)
            sobel_pkg::ST_IDLE:  if (start) state_next = sobel_pkg::ST_READ;
            sobel_pkg::ST_READ:  state_next = sobel_pkg::ST_WAIT;  // Single word per read
            sobel_pkg::ST_WAIT: begin
                if (unpack_idle) begin
                    state_next = (pix_left == '0) ? sobel_pkg::ST_DRAIN : sobel_pkg::ST_READ;
                end
            end
            sobel_pkg::ST_DRAIN: if (frame_done) state_next = sobel_pkg::ST_DONE;
            sobel_pkg::ST_DONE:  state_next = sobel_pkg::ST_IDLE;
            default:             state_next = sobel_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= sobel_pkg::ST_IDLE;
            frame_start <= 1'b0;
        end else begin
            state       <= state_next;
            frame_start <= (state == sobel_pkg::ST_IDLE) && start;
        end
    end

    // ------------------------------------------------------------------------
    // Configuration latch and read addressing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_width    <= '0;
            cfg_height   <= '0;
            cfg_mode     <= sobel_pkg::MODE_GX;
            pix_left     <= '0;
            bram_in_addr <= '0;
        end else if (state == sobel_pkg::ST_IDLE && start) begin
            cfg_width    <= image_width;   // Held for the whole frame
            cfg_height   <= image_height;
            cfg_mode     <= mode;
            pix_left     <= image_width * image_height;
            bram_in_addr <= '0;
        end else if (bram_in_ena) begin
            pix_left     <= pix_left - lane_count;
            bram_in_addr <= bram_in_addr + 1'b1;
        end
    end

    // Last word may hold fewer than four pixels
    assign lane_count  = (pix_left >= PIX_PER_WORD) ? LANE_CNT_W'(PIX_PER_WORD)
                                                    : LANE_CNT_W'(pix_left);
    assign bram_in_ena = (state == sobel_pkg::ST_READ);
    assign word_req    = bram_in_ena;
    assign busy        = (state != sobel_pkg::ST_IDLE) && (state != sobel_pkg::ST_DONE);
    assign done        = (state == sobel_pkg::ST_DONE);

    // Latched width must fit the line buffers for the whole frame
    a_width_range: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> (cfg_width >= 3 && cfg_width <= IMG_WIDTH_MAX))
        else $error("Latched image width out of range");

    // No read past the end of the image
    a_read_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        bram_in_ena |-> (pix_left != '0))
        else $error("Input RAM read outside a pending word");

endmodule

// File: logic/output_packer.sv
module output_packer #(
    parameter int DATA_WIDTH  = 32,
    parameter int PIXEL_WIDTH = 8,
    parameter int ADDR_WIDTH  = 10,
    localparam int PIX_PER_WORD = DATA_WIDTH / PIXEL_WIDTH,
    localparam int LANE_W       = $clog2(PIX_PER_WORD)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_start,
    input  logic                   res_valid,
    input  logic [PIXEL_WIDTH-1:0] res_pixel,
    input  logic                   res_last,
    output logic                   bram_out_wea,
    output logic [ADDR_WIDTH-1:0]  bram_out_addr,
    output logic [DATA_WIDTH-1:0]  bram_out_dina,
    output logic                   frame_done
);

    logic [LANE_W-1:0]     lane;      // Next free byte lane
    logic [DATA_WIDTH-1:0] acc;       // Lanes gathered so far, rest zero
    logic [DATA_WIDTH-1:0] acc_next;
    logic                  wr_last;   // Current write closes the frame
    logic                  word_full;

    always_comb begin
        acc_next = acc;
        acc_next[lane*PIXEL_WIDTH +: PIXEL_WIDTH] = res_pixel;
    end

    assign word_full = (lane == LANE_W'(PIX_PER_WORD - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane          <= '0;
            bram_out_wea  <= 1'b0;
            bram_out_addr <= '0;
            wr_last       <= 1'b0;
            frame_done    <= 1'b0;
        end else begin
            bram_out_wea <= res_valid && (word_full || res_last);
            wr_last      <= res_valid && res_last;
            frame_done   <= bram_out_wea && wr_last;
            if (frame_start) begin
                lane          <= '0;
                bram_out_addr <= '0;
            end else begin
                if (bram_out_wea) bram_out_addr <= bram_out_addr + 1'b1;  // Step after write
                if (res_valid) lane <= (word_full || res_last) ? '0 : lane + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start) begin
            acc <= '0;
        end else if (res_valid) begin
            if (word_full || res_last) begin
                bram_out_dina <= acc_next;  // Unfilled lanes stay zero
                acc           <= '0;
            end else begin
                acc <= acc_next;
            end
        end
    end

    // Each word lands at its own address
    a_addr_steps: assert property (@(posedge clk) disable iff (!rst_n)
        bram_out_wea |=> !(bram_out_wea && $stable(bram_out_addr)))
        else $error("Two output writes at one address");

endmodule

// File: logic/pixel_unpacker.sv
module pixel_unpacker #(
    parameter int DATA_WIDTH  = 32,
    parameter int PIXEL_WIDTH = 8,
    localparam int PIX_PER_WORD = DATA_WIDTH / PIXEL_WIDTH,
    localparam int LANE_CNT_W   = $clog2(PIX_PER_WORD + 1)
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   word_req,
    input  logic [LANE_CNT_W-1:0]  lane_count,
    input  logic [DATA_WIDTH-1:0]  bram_in_dout,
    output logic                   pix_valid,
    output logic [PIXEL_WIDTH-1:0] pix_data,
    output logic                   unpack_idle
);

    logic                  req_d;      // RAM data valid this cycle
    logic [LANE_CNT_W-1:0] lanes_q;    // Lane count of the pending word
    logic [LANE_CNT_W-1:0] left;       // Pixels still to emit
    logic [DATA_WIDTH-1:0] shift_word; // Lane 0 always at the bottom

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_d <= 1'b0;
            left  <= '0;
        end else begin
            req_d <= word_req;
            if (req_d) begin
                left <= lanes_q;
            end else if (left != '0) begin
                left <= left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_req) lanes_q <= lane_count;  // Sequencer moves on after the request
        if (req_d) begin
            shift_word <= bram_in_dout;
        end else if (left != '0) begin
            shift_word <= shift_word >> PIXEL_WIDTH;
        end
    end

    assign pix_valid   = (left != '0);
    assign pix_data    = shift_word[PIXEL_WIDTH-1:0];
    assign unpack_idle = !word_req && !req_d && (left == '0);

    // Sequencer must wait for the previous word to drain
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        word_req |-> (!req_d && left == '0))
        else $error("Word request while unpacker busy");

endmodule

// File: logic/sobel_filter.sv
module sobel_filter #(
    parameter int DATA_WIDTH    = 32,  // RAM word width
    parameter int PIXEL_WIDTH   = 8,
    parameter int ADDR_WIDTH    = 10,
    parameter int DIM_WIDTH     = 16,  // Width/height input width
    parameter int IMG_WIDTH_MAX = 64   // Line buffer depth
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Control
    input  logic                    start,
    input  sobel_pkg::sobel_mode_e  mode,
    input  logic [DIM_WIDTH-1:0]    image_width,
    input  logic [DIM_WIDTH-1:0]    image_height,
    output logic                    busy,
    output logic                    done,
    // Input RAM, read only
    output logic                    bram_in_ena,
    output logic [ADDR_WIDTH-1:0]   bram_in_addr,
    input  logic [DATA_WIDTH-1:0]   bram_in_dout,
    // Output RAM, write only
    output logic                    bram_out_wea,
    output logic [ADDR_WIDTH-1:0]   bram_out_addr,
    output logic [DATA_WIDTH-1:0]   bram_out_dina
);

    localparam int LANE_CNT_W = $clog2(DATA_WIDTH / PIXEL_WIDTH + 1);
    localparam int WIN_W      = sobel_pkg::KERNEL_SIZE * sobel_pkg::KERNEL_SIZE * PIXEL_WIDTH;

    logic                   word_req;     // Read pulse toward unpacker
    logic [LANE_CNT_W-1:0]  lane_count;   // Valid pixels in requested word
    logic                   unpack_idle;
    logic                   pix_valid;
    logic [PIXEL_WIDTH-1:0] pix_data;
    logic [DIM_WIDTH-1:0]   cfg_width;
    logic [DIM_WIDTH-1:0]   cfg_height;
    sobel_pkg::sobel_mode_e cfg_mode;
    logic                   frame_start;
    logic                   win_valid;
    logic [WIN_W-1:0]       win_pixels;   // 3x3 window, row major
    logic                   win_last;
    logic                   res_valid;
    logic [PIXEL_WIDTH-1:0] res_pixel;
    logic                   res_last;
    logic                   frame_done;

    frame_sequencer #(
        .DATA_WIDTH    (DATA_WIDTH),
        .PIXEL_WIDTH   (PIXEL_WIDTH),
        .ADDR_WIDTH    (ADDR_WIDTH),
        .DIM_WIDTH     (DIM_WIDTH),
        .IMG_WIDTH_MAX (IMG_WIDTH_MAX)
    ) u_seq (
        .clk, .rst_n, .start, .mode, .image_width, .image_height,
        .unpack_idle, .frame_done, .busy, .done, .bram_in_ena, .bram_in_addr,
        .word_req, .lane_count, .cfg_width, .cfg_height, .cfg_mode, .frame_start
    );

    pixel_unpacker #(.DATA_WIDTH(DATA_WIDTH), .PIXEL_WIDTH(PIXEL_WIDTH)) u_unpack (
        .clk, .rst_n, .word_req, .lane_count, .bram_in_dout,
        .pix_valid, .pix_data, .unpack_idle
    );

    window_builder #(
        .PIXEL_WIDTH   (PIXEL_WIDTH),
        .DIM_WIDTH     (DIM_WIDTH),
        .IMG_WIDTH_MAX (IMG_WIDTH_MAX)
    ) u_win (
        .clk, .rst_n, .frame_start, .cfg_width, .cfg_height,
        .pix_valid, .pix_data, .win_valid, .win_pixels, .win_last
    );

    sobel_kernel #(.PIXEL_WIDTH(PIXEL_WIDTH)) u_kernel (
        .clk, .rst_n, .cfg_mode, .win_valid, .win_pixels, .win_last,
        .res_valid, .res_pixel, .res_last
    );

    output_packer #(
        .DATA_WIDTH  (DATA_WIDTH),
        .PIXEL_WIDTH (PIXEL_WIDTH),
        .ADDR_WIDTH  (ADDR_WIDTH)
    ) u_pack (
        .clk, .rst_n, .frame_start, .res_valid, .res_pixel, .res_last,
        .bram_out_wea, .bram_out_addr, .bram_out_dina, .frame_done
    );

endmodule

// File: logic/sobel_kernel.sv
module sobel_kernel #(
    parameter int PIXEL_WIDTH = 8,
    localparam int K     = sobel_pkg::KERNEL_SIZE,
    localparam int CW    = sobel_pkg::CONV_WIDTH,
    localparam int WIN_W = K * K * PIXEL_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sobel_pkg::sobel_mode_e cfg_mode,
    input  logic                   win_valid,
    input  logic [WIN_W-1:0]       win_pixels,
    input  logic                   win_last,
    output logic                   res_valid,
    output logic [PIXEL_WIDTH-1:0] res_pixel,
    output logic                   res_last
);

    localparam logic [CW-1:0] PIX_MAX = CW'(2**PIXEL_WIDTH - 1);  // Saturation level

    logic signed [CW-1:0]   px [K*K];  // Zero extended, row major
    logic signed [CW-1:0]   gx;
    logic signed [CW-1:0]   gy;
    logic [CW-1:0]          abs_gx;
    logic [CW-1:0]          abs_gy;
    logic [CW-1:0]          mag;       // Max 2040, no overflow
    logic [PIXEL_WIDTH-1:0] sat_pixel;

    for (genvar i = 0; i < K*K; i++) begin : g_px
        assign px[i] = $signed({{(CW-PIXEL_WIDTH){1'b0}}, win_pixels[i*PIXEL_WIDTH +: PIXEL_WIDTH]});
    end

    always_comb begin
        gx = (px[2] + (px[5] <<< 1) + px[8]) - (px[0] + (px[3] <<< 1) + px[6]);  // Right - left
        gy = (px[0] + (px[1] <<< 1) + px[2]) - (px[6] + (px[7] <<< 1) + px[8]);  // Top - bottom
        abs_gx = gx[CW-1] ? CW'(-gx) : CW'(gx);
        abs_gy = gy[CW-1] ? CW'(-gy) : CW'(gy);
        unique case (cfg_mode)
            sobel_pkg::MODE_GX:   mag = abs_gx;
            sobel_pkg::MODE_GY:   mag = abs_gy;
            sobel_pkg::MODE_SUM:  mag = abs_gx + abs_gy;
            sobel_pkg::MODE_RSVD: mag = abs_gx + abs_gy;  // Same as sum
        endcase
        sat_pixel = (mag > PIX_MAX) ? '1 : mag[PIXEL_WIDTH-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res_last  <= 1'b0;
        end else begin
            res_valid <= win_valid;
            res_last  <= win_valid && win_last;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) res_pixel <= sat_pixel;
    end

endmodule

// File: logic/sobel_pkg.sv
package sobel_pkg;

    // ------------------------------------------------------------------------
    // Gradient selection
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        MODE_GX   = 2'd0,  // |Gx| only
        MODE_GY   = 2'd1,  // |Gy| only
        MODE_SUM  = 2'd2,  // |Gx| + |Gy|
        MODE_RSVD = 2'd3   // Treated as MODE_SUM
    } sobel_mode_e;

    // ------------------------------------------------------------------------
    // Frame sequencer states
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,  // Waiting for start
        ST_READ  = 3'd1,  // One input word read
        ST_WAIT  = 3'd2,  // Unpacker emitting pixels
        ST_DRAIN = 3'd3,  // Pipeline flushing to output RAM
        ST_DONE  = 3'd4   // One-cycle done
    } seq_state_e;

    localparam int KERNEL_SIZE = 3;   // Window edge length
    localparam int CONV_WIDTH  = 12;  // Signed Gx/Gy width, holds +-1020

endpackage

// File: logic/window_builder.sv
module window_builder #(
    parameter int PIXEL_WIDTH   = 8,
    parameter int DIM_WIDTH     = 16,
    parameter int IMG_WIDTH_MAX = 64,
    localparam int K     = sobel_pkg::KERNEL_SIZE,
    localparam int WIN_W = K * K * PIXEL_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_start,
    input  logic [DIM_WIDTH-1:0]   cfg_width,
    input  logic [DIM_WIDTH-1:0]   cfg_height,
    input  logic                   pix_valid,
    input  logic [PIXEL_WIDTH-1:0] pix_data,
    output logic                   win_valid,
    output logic [WIN_W-1:0]       win_pixels,
    output logic                   win_last
);

    localparam int LB_AW = $clog2(IMG_WIDTH_MAX);
    localparam logic [DIM_WIDTH-1:0] EDGE = DIM_WIDTH'(K - 1);  // First interior index + 1

    logic [DIM_WIDTH-1:0]   col_cnt;
    logic [DIM_WIDTH-1:0]   row_cnt;
    logic [LB_AW-1:0]       lb_idx;
    logic [PIXEL_WIDTH-1:0] line_top [IMG_WIDTH_MAX];  // Row r-2
    logic [PIXEL_WIDTH-1:0] line_mid [IMG_WIDTH_MAX];  // Row r-1
    logic [PIXEL_WIDTH-1:0] win [K][K];                // [row][col], col 2 newest

    assign lb_idx = col_cnt[LB_AW-1:0];

    // ------------------------------------------------------------------------
    // Raster position
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
            win_last  <= 1'b0;
        end else begin
            win_valid <= pix_valid && row_cnt >= EDGE && col_cnt >= EDGE;
            win_last  <= pix_valid && row_cnt == cfg_height - 1'b1
                                   && col_cnt == cfg_width - 1'b1;
            if (frame_start) begin
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (pix_valid) begin
                if (col_cnt == cfg_width - 1'b1) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Line buffers and window shift
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            line_top[lb_idx] <= line_mid[lb_idx];  // Age column by one row
            line_mid[lb_idx] <= pix_data;
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++) begin
                    win[r][c] <= win[r][c+1];
                end
            end
            win[0][K-1] <= line_top[lb_idx];
            win[1][K-1] <= line_mid[lb_idx];
            win[2][K-1] <= pix_data;
        end
    end

    for (genvar r = 0; r < K; r++) begin : g_row
        for (genvar c = 0; c < K; c++) begin : g_col
            assign win_pixels[(r*K + c)*PIXEL_WIDTH +: PIXEL_WIDTH] = win[r][c];
        end
    end

endmodule

// File: sources.f
logic/sobel_pkg.sv
logic/frame_sequencer.sv
logic/pixel_unpacker.sv
logic/window_builder.sv
logic/sobel_kernel.sv
logic/output_packer.sv
logic/sobel_filter.sv
verification/sobel_tb.sv

// File: verification/sobel_stimulus.txt
# name width height mode(0 gx, 1 gy, 2 sum, 3 rsvd) fill(const hramp vramp random)
# fill value (pixel, step, unused for random) and expected output word count
const_gx 8 6 0 const 77 6
const_sum 10 5 2 const 200 6
hramp_gx 12 4 0 hramp 5 5
hramp_sat 6 5 0 hramp 40 3
hramp_gy 12 4 1 hramp 5 5
vramp_gy 7 9 1 vramp 6 9
vramp_gx 7 9 0 vramp 6 9
rand_w5 5 7 2 random 0 4
rand_w13 13 6 3 random 0 11
rand_w30 30 11 2 random 0 63
rand_w64 64 8 3 random 0 93
rand_w3 3 3 2 random 0 1
rand_w9 9 4 0 random 0 4
rand_w17 17 10 1 random 0 30

// File: verification/sobel_tb.sv
module sobel_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT   = 20000;  // Cycles allowed per wait
    localparam int RAM_DEPTH = 1024;
    localparam int IMG_MAX   = 4096;   // 64 x 64 pixels

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    sobel_pkg::sobel_mode_e mode;
    logic [15:0]            image_width;
    logic [15:0]            image_height;
    logic                   busy;
    logic                   done;
    logic                   bram_in_ena;
    logic [9:0]             bram_in_addr;
    logic [31:0]            bram_in_dout;
    logic                   bram_out_wea;
    logic [9:0]             bram_out_addr;
    logic [31:0]            bram_out_dina;

    logic [31:0] in_mem  [RAM_DEPTH];
    logic [31:0] out_mem [RAM_DEPTH];  // Written by the output RAM model only
    logic [31:0] exp_mem [RAM_DEPTH];
    int          wr_tag  [RAM_DEPTH];  // Test number of the last write per address
    logic [7:0]  img     [IMG_MAX];    // Current image, raster order
    int          test_id;
    int          wr_total;             // All output writes since time 0
    int          first_addr;           // First write address of the current test
    int          last_tag;
    logic [31:0] rng;
    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;

    sobel_filter #(
        .DATA_WIDTH    (32),
        .PIXEL_WIDTH   (8),
        .ADDR_WIDTH    (10),
        .DIM_WIDTH     (16),
        .IMG_WIDTH_MAX (64)
    ) u_dut (
        .clk, .rst_n, .start, .mode, .image_width, .image_height, .busy, .done,
        .bram_in_ena, .bram_in_addr, .bram_in_dout,
        .bram_out_wea, .bram_out_addr, .bram_out_dina
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // ------------------------------------------------------------------------
    // RAM models
    // ------------------------------------------------------------------------
    initial begin
        bram_in_dout <= '0;
        forever begin
            @(posedge clk);
            if (bram_in_ena) bram_in_dout <= in_mem[bram_in_addr];  // 1-cycle latency
        end
    end

    always @(posedge clk) begin
        if (bram_out_wea) begin
            if (last_tag != test_id) begin
                first_addr = bram_out_addr;  // Start of a new frame
                last_tag   = test_id;
            end
            out_mem[bram_out_addr] = bram_out_dina;
            wr_tag[bram_out_addr]  = test_id;
            wr_total               = wr_total + 1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Sobel result for the window centred on (r, c)
    function automatic int ref_pixel(input int r, input int c, input int w, input int m);
        int p [3][3];
        int gx;
        int gy;
        int mag;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) p[i][j] = img[(r - 1 + i) * w + c - 1 + j];
        end
        gx = (p[0][2] + 2 * p[1][2] + p[2][2]) - (p[0][0] + 2 * p[1][0] + p[2][0]);
        gy = (p[0][0] + 2 * p[0][1] + p[0][2]) - (p[2][0] + 2 * p[2][1] + p[2][2]);
        gx = (gx < 0) ? -gx : gx;
        gy = (gy < 0) ? -gy : gy;
        case (m)
            0:       mag = gx;
            1:       mag = gy;
            default: mag = gx + gy;  // Sum, reserved code too
        endcase
        return (mag > 255) ? 255 : mag;
    endfunction

    task automatic fill_image(input string kind, input int w, input int h, input int val);
        for (int p = 0; p < IMG_MAX; p++) begin
            if (p >= w * h) begin
                img[p] = 8'd0;
            end else if (kind == "hramp") begin
                img[p] = 8'((p % w) * val);  // Column times step
            end else if (kind == "vramp") begin
                img[p] = 8'((p / w) * val);  // Row times step
            end else if (kind == "random") begin
                rng    = xorshift(rng);
                img[p] = rng[7:0];
            end else begin
                img[p] = 8'(val);
            end
        end
        for (int i = 0; i < (w * h + 3) / 4; i++) begin
            in_mem[i] = {img[4*i+3], img[4*i+2], img[4*i+1], img[4*i]};  // Pixel 0 low
        end
    endtask

    task automatic build_expected(input int w, input int h, input int m, output int words);
        int k;
        k = 0;
        for (int a = 0; a < RAM_DEPTH; a++) exp_mem[a] = '0;  // Padding bytes stay zero
        for (int r = 1; r < h - 1; r++) begin
            for (int c = 1; c < w - 1; c++) begin
                exp_mem[k / 4][8 * (k % 4) +: 8] = 8'(ref_pixel(r, c, w, m));
                k++;
            end
        end
        words = (k + 3) / 4;
    endtask

    task automatic wait_busy(input string name, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < TIMEOUT && !ok; i++) begin
            @(posedge clk);
            ok = busy;
        end
        if (!ok) $display("Timeout in %0s: busy never rose after start", name);
    endtask

    task automatic wait_done(input string name, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < TIMEOUT && !ok; i++) begin
            @(posedge clk);
            ok = done;
            assert (done || busy) else begin
                $display("In %0s busy fell before done", name);
                errors++;
            end
        end
        if (!ok) $display("Timeout in %0s: done never came", name);
    endtask

    // ------------------------------------------------------------------------
    // One frame from start to result check
    // ------------------------------------------------------------------------
    task automatic run_test(input string name, input int w, input int h, input int m,
                            input string kind, input int val, input int nwords);
        int  calc_words;
        int  base;
        int  err_before;
        bit  ok;
        err_before = errors;
        test_id++;
        fill_image(kind, w, h, val);
        build_expected(w, h, m, calc_words);
        assert (calc_words == nwords) else begin
            $display("MISMATCH %0s word count expected %0d actual %0d", name, calc_words, nwords);
            errors++;
        end
        assert (!busy && !done) else begin
            $display("In %0s the DUT was not idle before start", name);
            errors++;
        end
        base = wr_total;
        @(posedge clk);
        start        <= 1'b1;
        mode         <= sobel_pkg::sobel_mode_e'(m[1:0]);
        image_width  <= 16'(w);
        image_height <= 16'(h);
        @(posedge clk);
        start <= 1'b0;
        wait_busy(name, ok);
        if (ok) begin
            @(posedge clk);
            start        <= 1'b1;  // Ignored while busy
            mode         <= sobel_pkg::sobel_mode_e'(m[1:0] ^ 2'd1);
            image_width  <= 16'd3;
            @(posedge clk);
            start        <= 1'b0;
            mode         <= sobel_pkg::sobel_mode_e'(m[1:0]);
            image_width  <= 16'(w);
            wait_done(name, ok);
        end
        if (!ok) begin
            timed_out = 1'b1;
            errors++;
        end else begin
            @(posedge clk);
            assert (!done && !busy) else begin
                $display("In %0s done lasted more than one cycle or busy stayed high", name);
                errors++;
            end
            assert (wr_total - base == nwords) else begin
                $display("MISMATCH %0s writes expected %0d actual %0d", name, nwords,
                         wr_total - base);
                errors++;
            end
            assert (first_addr == 0) else begin
                $display("MISMATCH %0s first address expected 0 actual %0d", name, first_addr);
                errors++;
            end
            for (int a = 0; a < RAM_DEPTH; a++) begin
                if (a < nwords) begin
                    assert (out_mem[a] == exp_mem[a]) else begin
                        $display("MISMATCH %0s word %0d expected %08h actual %08h",
                                 name, a, exp_mem[a], out_mem[a]);
                        errors++;
                    end
                end else begin
                    assert (wr_tag[a] != test_id) else begin
                        $display("In %0s a word was written past the end at %0d", name, a);
                        errors++;
                    end
                end
            end
        end
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("test %0s %0dx%0d mode %0d: %0s", name, w, h, m,
                 (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        int    fd;
        int    n;
        int    w;
        int    h;
        int    m;
        int    val;
        int    nwords;
        string line;
        string name;
        string kind;
        rst_n        <= 1'b0;
        start        <= 1'b0;
        mode         <= sobel_pkg::MODE_GX;
        image_width  <= '0;
        image_height <= '0;
        rng          = 32'd8683;
        test_id      = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!busy && !done && !bram_in_ena && !bram_out_wea) else begin
            $display("busy, done or a RAM strobe high after reset");
            errors++;
        end
        fd = $fopen("verification/sobel_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                n = $fgets(line, fd);
                if (n > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %d %s %d %d", name, w, h, m, kind, val, nwords);
                    if (n == 7) run_test(name, w, h, m, kind, val, nwords);
                end
            end
            $fclose(fd);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
